// ==== common/spu_odd_pkg.sv ====
// odd pipe shared definitions
// widths, operand types, opcode encoding and local store constants

package spu_odd_pkg;

    // bit 0 is the most significant bit in every vector
    localparam int QUAD_BITS     = 128;
    localparam int WORD_BITS     = 32;
    localparam int BYTE_BITS     = 8;
    localparam int QUAD_BYTES    = QUAD_BITS / BYTE_BITS;
    localparam int REG_ADDR_BITS = 7;
    localparam int IMM7_BITS     = 7;
    localparam int IMM10_BITS    = 10;
    localparam int IMM16_BITS    = 16;
    localparam int OPCODE_BITS   = 5;

    typedef logic [0:QUAD_BITS-1]     quad_t;
    typedef logic [0:WORD_BITS-1]     word_t;
    typedef logic [0:REG_ADDR_BITS-1] reg_addr_t;
    typedef logic [0:IMM7_BITS-1]     imm7_t;
    typedef logic [0:IMM10_BITS-1]    imm10_t;
    typedef logic [0:IMM16_BITS-1]    imm16_t;

    typedef enum logic [OPCODE_BITS-1:0] {
        OP_LNOP,
        // permute
        OP_SHLQBI,
        OP_SHLQBYI,
        OP_ROTQBY,
        OP_ROTQBYI,
        OP_GBB,
        OP_SHUFB,
        // load and store
        OP_LQD,
        OP_LQX,
        OP_STQD,
        OP_STQX,
        // branch
        OP_BR,
        OP_BRA,
        OP_BRSL,
        OP_BRZ,
        OP_BRNZ
    } odd_op_t;

    // local store size in bytes, power of two
    localparam int LS_BYTES_DEFAULT = 4096;

    // quadword and word alignment of addresses
    localparam word_t QW_ALIGN_MASK   = 32'hFFFF_FFF0;
    localparam word_t WORD_ALIGN_MASK = 32'hFFFF_FFFC;

endpackage

// ==== common/odd_issue_if.sv ====
// issue bus of the odd pipe
// operands of one instruction, shared by the permute, load/store and branch units

`timescale 1ns/1ps

interface odd_issue_if;
    import spu_odd_pkg::*;

    odd_op_t   opcode;
    quad_t     ra;
    quad_t     rb;
    quad_t     rc;
    reg_addr_t rt_addr;
    imm7_t     imm7;
    imm10_t    imm10;
    imm16_t    imm16;
    word_t     pc;

    modport issue (
        output opcode, ra, rb, rc, rt_addr, imm7, imm10, imm16, pc
    );

    modport unit (
        input opcode, ra, rb, rc, rt_addr, imm7, imm10, imm16, pc
    );

endinterface

// ==== hdl/result_delay.sv ====
// writeback delay line
// shifts register write packets by DEPTH stages, frozen while the core stalls

`timescale 1ns/1ps

module result_delay #(
    parameter int DEPTH = 1
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   stall,
    input  logic                   in_wr_en,
    input  spu_odd_pkg::reg_addr_t in_rt_addr,
    input  spu_odd_pkg::quad_t     in_value,
    output logic                   out_wr_en,
    output spu_odd_pkg::reg_addr_t out_rt_addr,
    output spu_odd_pkg::quad_t     out_value
);
    import spu_odd_pkg::*;

    logic      wr_en_q   [DEPTH];
    reg_addr_t rt_addr_q [DEPTH];
    quad_t     value_q   [DEPTH];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                wr_en_q[i]   <= 1'b0;
                rt_addr_q[i] <= '0;
                value_q[i]   <= '0;
            end
        end else if (!stall) begin
            wr_en_q[0]   <= in_wr_en;
            rt_addr_q[0] <= in_rt_addr;
            value_q[0]   <= in_value;
            for (int i = 1; i < DEPTH; i++) begin
                wr_en_q[i]   <= wr_en_q[i-1];
                rt_addr_q[i] <= rt_addr_q[i-1];
                value_q[i]   <= value_q[i-1];
            end
        end
    end

    assign out_wr_en   = wr_en_q[DEPTH-1];
    assign out_rt_addr = rt_addr_q[DEPTH-1];
    assign out_value   = value_q[DEPTH-1];

endmodule

// ==== hdl/branch_unit.sv ====
// branch unit
// computes target and taken state, raises flush and returns the brsl link value

`timescale 1ns/1ps

module branch_unit #(
    parameter int LS_BYTES = spu_odd_pkg::LS_BYTES_DEFAULT
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   stall,
    input  logic                   br_first_instr,
    odd_issue_if.unit              bus,
    output logic                   branch_taken,
    output logic                   flush,
    output spu_odd_pkg::word_t     bta,
    output logic                   wr_en,
    output spu_odd_pkg::reg_addr_t rt_addr,
    output spu_odd_pkg::quad_t     value
);
    import spu_odd_pkg::*;

    localparam word_t LS_MASK = word_t'(LS_BYTES - 1);

    word_t offset;
    word_t rel_target;
    word_t next_pc;
    word_t target;
    logic  is_branch;
    logic  taken;
    quad_t link_value;

    // word offset, sign extended
    assign offset     = {{(WORD_BITS-IMM16_BITS-2){bus.imm16[0]}}, bus.imm16, 2'b00};
    assign rel_target = bus.pc + offset;
    assign next_pc    = bus.pc + 32'd4;
    assign link_value = {next_pc & LS_MASK, {(QUAD_BITS-WORD_BITS){1'b0}}};

    always_comb begin
        is_branch = 1'b1;
        taken     = 1'b1;
        target    = next_pc;
        case (bus.opcode)
            OP_BR, OP_BRSL: target = rel_target & LS_MASK;
            OP_BRA:         target = offset & LS_MASK;
            OP_BRZ: begin
                taken = (bus.rc[0:WORD_BITS-1] == '0);
                if (taken) begin
                    target = rel_target & WORD_ALIGN_MASK;
                end
            end
            OP_BRNZ: begin
                taken = (bus.rc[0:WORD_BITS-1] != '0);
                if (taken) begin
                    target = rel_target & WORD_ALIGN_MASK;
                end
            end
            default: begin
                is_branch = 1'b0;
                taken     = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            branch_taken <= 1'b0;
            flush        <= 1'b0;
            bta          <= '0;
            wr_en        <= 1'b0;
            rt_addr      <= '0;
            value        <= '0;
        end else if (!stall) begin
            // link packet slot advances on every edge
            wr_en   <= (bus.opcode == OP_BRSL);
            rt_addr <= bus.rt_addr;
            value   <= (bus.opcode == OP_BRSL) ? link_value : '0;
            // lnop is not an issued instruction, control state holds
            if (bus.opcode != OP_LNOP) begin
                branch_taken <= taken;
                flush        <= taken & br_first_instr;
            end
            if (is_branch) begin
                bta <= target;
            end
        end
    end

endmodule

// ==== permute/permute_unit.sv ====
// permute unit
// quadword shifts, byte rotates, gather bits from bytes and shuffle bytes, one register stage

`timescale 1ns/1ps

module permute_unit (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   stall,
    odd_issue_if.unit              bus,
    output logic                   wr_en,
    output spu_odd_pkg::reg_addr_t rt_addr,
    output spu_odd_pkg::quad_t     value
);
    import spu_odd_pkg::*;

    logic [0:4] shift_bytes;
    quad_t      result;
    logic       is_perm;

    // left rotate by whole bytes, bits leaving byte 0 reenter at byte 15
    function automatic quad_t rotl_bytes(quad_t q, logic [3:0] n);
        logic [0:2*QUAD_BITS-1] dbl;
        dbl = {q, q} << (n * BYTE_BITS);
        return dbl[0:QUAD_BITS-1];
    endfunction

    // each control byte picks a constant or one of the 32 bytes of a:b
    function automatic quad_t shuffle_bytes(quad_t a, quad_t b, quad_t c);
        logic [0:2*QUAD_BITS-1] cat;
        logic [0:BYTE_BITS-1]   ctl;
        quad_t                  res;
        cat = {a, b};
        res = '0;
        for (int j = 0; j < QUAD_BYTES; j++) begin
            ctl = c[BYTE_BITS*j +: BYTE_BITS];
            if (ctl[0:1] == 2'b10) begin
                res[BYTE_BITS*j +: BYTE_BITS] = 8'h00;
            end else if (ctl[0:2] == 3'b110) begin
                res[BYTE_BITS*j +: BYTE_BITS] = 8'hFF;
            end else if (ctl[0:2] == 3'b111) begin
                res[BYTE_BITS*j +: BYTE_BITS] = 8'h80;
            end else begin
                res[BYTE_BITS*j +: BYTE_BITS] = cat[BYTE_BITS*ctl[3:7] +: BYTE_BITS];
            end
        end
        return res;
    endfunction

    assign shift_bytes = bus.imm7[2:6];

    always_comb begin
        result  = '0;
        is_perm = 1'b1;
        case (bus.opcode)
            // zero fill from the right
            OP_SHLQBI: result = bus.ra << bus.rb[29:31];
            OP_SHLQBYI: begin
                if (shift_bytes < QUAD_BYTES) begin
                    result = bus.ra << (shift_bytes * BYTE_BITS);
                end
            end
            OP_ROTQBY:  result = rotl_bytes(bus.ra, bus.rb[28:31]);
            OP_ROTQBYI: result = rotl_bytes(bus.ra, bus.imm7[3:6]);
            OP_GBB: begin
                // last bit of each byte, byte 0 lands in bit 16
                for (int i = 0; i < QUAD_BYTES; i++) begin
                    result[WORD_BITS-QUAD_BYTES+i] = bus.ra[BYTE_BITS*i + BYTE_BITS-1];
                end
            end
            OP_SHUFB: result = shuffle_bytes(bus.ra, bus.rb, bus.rc);
            default:  is_perm = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_en   <= 1'b0;
            rt_addr <= '0;
            value   <= '0;
        end else if (!stall) begin
            wr_en   <= is_perm;
            rt_addr <= bus.rt_addr;
            value   <= result;
        end
    end

endmodule

// ==== load_store/local_store.sv ====
// local store
// quadword wide memory, synchronous write and registered read, frozen on stall

`timescale 1ns/1ps

module local_store #(
    parameter int LS_BYTES = spu_odd_pkg::LS_BYTES_DEFAULT
) (
    input  logic               clk,
    input  logic               stall,
    input  logic               write,
    input  spu_odd_pkg::word_t addr,
    input  spu_odd_pkg::quad_t wdata,
    output spu_odd_pkg::quad_t rdata
);
    import spu_odd_pkg::*;

    localparam int LINES  = LS_BYTES / QUAD_BYTES;
    localparam int IDX_W  = $clog2(LINES);
    localparam int OFFS_W = $clog2(QUAD_BYTES);

    quad_t            mem [LINES];
    logic [IDX_W-1:0] idx;

    // drop the byte offset within the quadword
    assign idx = IDX_W'(addr >> OFFS_W);

    always_ff @(posedge clk) begin
        if (!stall) begin
            if (write) begin
                mem[idx] <= wdata;
            end
            rdata <= mem[idx];
        end
    end

endmodule

// ==== load_store/ls_unit.sv ====
// load/store unit
// d-form and x-form address generation, local store access and load writeback

`timescale 1ns/1ps

module ls_unit #(
    parameter int LS_BYTES = spu_odd_pkg::LS_BYTES_DEFAULT
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   stall,
    odd_issue_if.unit              bus,
    output logic                   wr_en,
    output spu_odd_pkg::reg_addr_t rt_addr,
    output spu_odd_pkg::quad_t     value
);
    import spu_odd_pkg::*;

    localparam word_t LS_MASK = word_t'(LS_BYTES - 1);

    word_t     d_addr;
    word_t     x_addr;
    word_t     ls_addr;
    logic      is_load;
    logic      is_store;
    logic      x_form;
    quad_t     rdata;
    logic      wr_en_q;
    reg_addr_t rt_addr_q;

    assign is_load  = (bus.opcode == OP_LQD) || (bus.opcode == OP_LQX);
    assign is_store = (bus.opcode == OP_STQD) || (bus.opcode == OP_STQX);
    assign x_form   = (bus.opcode == OP_LQX) || (bus.opcode == OP_STQX);

    // imm10 counts quadwords, sign extended
    assign d_addr = bus.ra[0:WORD_BITS-1]
                  + {{(WORD_BITS-IMM10_BITS-4){bus.imm10[0]}}, bus.imm10, 4'b0000};
    assign x_addr = bus.ra[0:WORD_BITS-1] + bus.rb[0:WORD_BITS-1];

    assign ls_addr = (x_form ? x_addr : d_addr) & LS_MASK & QW_ALIGN_MASK;

    local_store #(
        .LS_BYTES (LS_BYTES)
    ) local_store_inst (
        .clk   (clk),
        .stall (stall),
        .write (is_store),
        .addr  (ls_addr),
        .wdata (bus.rc),
        .rdata (rdata)
    );

    // control fields line up with the registered read data
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_en_q   <= 1'b0;
            rt_addr_q <= '0;
        end else if (!stall) begin
            wr_en_q   <= is_load;
            rt_addr_q <= bus.rt_addr;
        end
    end

    assign wr_en   = wr_en_q;
    assign rt_addr = rt_addr_q;
    // stores and idle slots carry a zero value
    assign value   = wr_en_q ? rdata : '0;

endmodule

// ==== hdl/odd_pipe.sv ====
// odd execution pipe of the SPU core
// permute, load/store and branch units with stallable writeback delay lines

`timescale 1ns/1ps

module odd_pipe #(
    parameter int LS_BYTES = spu_odd_pkg::LS_BYTES_DEFAULT
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   stall,
    input  logic                   br_first_instr,
    input  spu_odd_pkg::odd_op_t   opcode,
    input  spu_odd_pkg::quad_t     ra,
    input  spu_odd_pkg::quad_t     rb,
    input  spu_odd_pkg::quad_t     rc,
    input  spu_odd_pkg::reg_addr_t rt_addr,
    input  spu_odd_pkg::imm7_t     imm7,
    input  spu_odd_pkg::imm10_t    imm10,
    input  spu_odd_pkg::imm16_t    imm16,
    input  spu_odd_pkg::word_t     pc,
    output logic                   branch_taken,
    output logic                   flush,
    output spu_odd_pkg::word_t     bta,
    output logic                   perm_wr_en,
    output spu_odd_pkg::reg_addr_t perm_rt_addr,
    output spu_odd_pkg::quad_t     perm_value,
    output logic                   ls_wr_en,
    output spu_odd_pkg::reg_addr_t ls_rt_addr,
    output spu_odd_pkg::quad_t     ls_value,
    output logic                   branch_wr_en,
    output spu_odd_pkg::reg_addr_t branch_rt_addr,
    output spu_odd_pkg::quad_t     branch_value
);
    import spu_odd_pkg::*;

    // unit packets before their delay lines
    logic      perm_u_wr_en;
    reg_addr_t perm_u_rt_addr;
    quad_t     perm_u_value;
    logic      ls_u_wr_en;
    reg_addr_t ls_u_rt_addr;
    quad_t     ls_u_value;
    logic      br_u_wr_en;
    reg_addr_t br_u_rt_addr;
    quad_t     br_u_value;

    odd_issue_if issue_bus ();

    assign issue_bus.opcode  = opcode;
    assign issue_bus.ra      = ra;
    assign issue_bus.rb      = rb;
    assign issue_bus.rc      = rc;
    assign issue_bus.rt_addr = rt_addr;
    assign issue_bus.imm7    = imm7;
    assign issue_bus.imm10   = imm10;
    assign issue_bus.imm16   = imm16;
    assign issue_bus.pc      = pc;

    permute_unit permute_unit_inst (
        .clk     (clk),
        .reset   (reset),
        .stall   (stall),
        .bus     (issue_bus.unit),
        .wr_en   (perm_u_wr_en),
        .rt_addr (perm_u_rt_addr),
        .value   (perm_u_value)
    );

    ls_unit #(
        .LS_BYTES (LS_BYTES)
    ) ls_unit_inst (
        .clk     (clk),
        .reset   (reset),
        .stall   (stall),
        .bus     (issue_bus.unit),
        .wr_en   (ls_u_wr_en),
        .rt_addr (ls_u_rt_addr),
        .value   (ls_u_value)
    );

    branch_unit #(
        .LS_BYTES (LS_BYTES)
    ) branch_unit_inst (
        .clk            (clk),
        .reset          (reset),
        .stall          (stall),
        .br_first_instr (br_first_instr),
        .bus            (issue_bus.unit),
        .branch_taken   (branch_taken),
        .flush          (flush),
        .bta            (bta),
        .wr_en          (br_u_wr_en),
        .rt_addr        (br_u_rt_addr),
        .value          (br_u_value)
    );

    // permute result leaves two edges after issue
    result_delay #(.DEPTH(1)) perm_delay (
        .clk         (clk),
        .reset       (reset),
        .stall       (stall),
        .in_wr_en    (perm_u_wr_en),
        .in_rt_addr  (perm_u_rt_addr),
        .in_value    (perm_u_value),
        .out_wr_en   (perm_wr_en),
        .out_rt_addr (perm_rt_addr),
        .out_value   (perm_value)
    );

    // load data leaves five edges after issue
    result_delay #(.DEPTH(4)) ls_delay (
        .clk         (clk),
        .reset       (reset),
        .stall       (stall),
        .in_wr_en    (ls_u_wr_en),
        .in_rt_addr  (ls_u_rt_addr),
        .in_value    (ls_u_value),
        .out_wr_en   (ls_wr_en),
        .out_rt_addr (ls_rt_addr),
        .out_value   (ls_value)
    );

    result_delay #(.DEPTH(1)) branch_delay (
        .clk         (clk),
        .reset       (reset),
        .stall       (stall),
        .in_wr_en    (br_u_wr_en),
        .in_rt_addr  (br_u_rt_addr),
        .in_value    (br_u_value),
        .out_wr_en   (branch_wr_en),
        .out_rt_addr (branch_rt_addr),
        .out_value   (branch_value)
    );

endmodule

// ==== test/odd_pipe_sva.sv ====
// odd pipe checker
// control output, reset and stall properties, bound into the top level

`timescale 1ns/1ps

module odd_pipe_sva (
    input logic                   clk,
    input logic                   reset,
    input logic                   stall,
    input logic                   branch_taken,
    input logic                   flush,
    input spu_odd_pkg::word_t     bta,
    input logic                   perm_wr_en,
    input spu_odd_pkg::reg_addr_t perm_rt_addr,
    input spu_odd_pkg::quad_t     perm_value,
    input logic                   ls_wr_en,
    input spu_odd_pkg::reg_addr_t ls_rt_addr,
    input spu_odd_pkg::quad_t     ls_value,
    input logic                   branch_wr_en,
    input spu_odd_pkg::reg_addr_t branch_rt_addr,
    input spu_odd_pkg::quad_t     branch_value
);

    // flush only accompanies a taken branch
    flush_needs_taken: assert property (@(posedge clk) disable iff (reset)
        flush |-> branch_taken)
        else $error("flush raised without branch_taken");

    outputs_idle_after_reset: assert property (@(posedge clk)
        reset |=> !perm_wr_en && !ls_wr_en && !branch_wr_en && !branch_taken && !flush
                  && perm_value == '0 && ls_value == '0 && branch_value == '0)
        else $error("outputs active in the cycle after reset");

    // a stalled edge changes no output
    outputs_hold_on_stall: assert property (@(posedge clk) disable iff (reset)
        (stall && !reset) |=> $stable({branch_taken, flush, bta,
                                       perm_wr_en, perm_rt_addr, perm_value,
                                       ls_wr_en, ls_rt_addr, ls_value,
                                       branch_wr_en, branch_rt_addr, branch_value}))
        else $error("outputs changed across a stalled edge");

endmodule

bind odd_pipe odd_pipe_sva odd_pipe_sva_inst (.*);

// ==== test/tb_odd_pipe.sv ====
// testbench for the odd pipe
// random instruction stream with stalls, checked against a reference model

`timescale 1ns/1ps

module tb_odd_pipe;
    import spu_odd_pkg::*;

    localparam int LS_BYTES    = 4096;
    localparam int NUM_INSTR   = 3000;
    localparam int MAX_CYCLES  = 6000;
    localparam int DRAIN_LIMIT = 20;
    // quadword lines reachable by the random load/store addresses
    localparam int LS_LINES    = 16;
    localparam int OUT_BITS    = 2 + WORD_BITS + 3 * (1 + REG_ADDR_BITS + QUAD_BITS);

    typedef struct packed {
        int        due;
        reg_addr_t rt;
        quad_t     value;
    } pkt_t;

    logic      clk = 1'b0;
    logic      reset;
    logic      stall;
    logic      br_first_instr;
    odd_op_t   opcode;
    quad_t     ra;
    quad_t     rb;
    quad_t     rc;
    reg_addr_t rt_addr;
    imm7_t     imm7;
    imm10_t    imm10;
    imm16_t    imm16;
    word_t     pc;
    logic      branch_taken;
    logic      flush;
    word_t     bta;
    logic      perm_wr_en;
    logic      ls_wr_en;
    logic      branch_wr_en;
    reg_addr_t perm_rt_addr;
    reg_addr_t ls_rt_addr;
    reg_addr_t branch_rt_addr;
    quad_t     perm_value;
    quad_t     ls_value;
    quad_t     branch_value;

    // reference model state
    pkt_t                perm_q [$];
    pkt_t                ls_q [$];
    pkt_t                br_q [$];
    quad_t               ls_mem [word_t];
    int                  edge_cnt;
    logic                exp_taken;
    logic                exp_flush;
    word_t               exp_bta;
    logic [OUT_BITS-1:0] snap;
    int                  issued;
    int                  cycles;
    int                  wait_cycles;

    odd_pipe #(
        .LS_BYTES (LS_BYTES)
    ) odd_pipe_inst (
        .clk            (clk),
        .reset          (reset),
        .stall          (stall),
        .br_first_instr (br_first_instr),
        .opcode         (opcode),
        .ra             (ra),
        .rb             (rb),
        .rc             (rc),
        .rt_addr        (rt_addr),
        .imm7           (imm7),
        .imm10          (imm10),
        .imm16          (imm16),
        .pc             (pc),
        .branch_taken   (branch_taken),
        .flush          (flush),
        .bta            (bta),
        .perm_wr_en     (perm_wr_en),
        .perm_rt_addr   (perm_rt_addr),
        .perm_value     (perm_value),
        .ls_wr_en       (ls_wr_en),
        .ls_rt_addr     (ls_rt_addr),
        .ls_value       (ls_value),
        .branch_wr_en   (branch_wr_en),
        .branch_rt_addr (branch_rt_addr),
        .branch_value   (branch_value)
    );

    always #4 clk = ~clk;

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped after first error");
    endtask

    function automatic logic [OUT_BITS-1:0] outputs_now();
        return {branch_taken, flush, bta,
                perm_wr_en, perm_rt_addr, perm_value,
                ls_wr_en, ls_rt_addr, ls_value,
                branch_wr_en, branch_rt_addr, branch_value};
    endfunction

    // byte j of the result taken from byte j+n, zero past the end unless rotating
    function automatic quad_t perm_model(odd_op_t op, quad_t a, quad_t b, quad_t c, imm7_t i7);
        quad_t       r;
        int          n;
        int          src;
        logic [7:0]  ctl;
        logic [15:0] gathered;
        r = '0;
        case (op)
            OP_SHLQBI: begin
                n = b[29:31];
                for (int i = 0; i < QUAD_BITS; i++) begin
                    if (i + n < QUAD_BITS) begin
                        r[i] = a[i + n];
                    end
                end
            end
            OP_SHLQBYI, OP_ROTQBY, OP_ROTQBYI: begin
                if (op == OP_SHLQBYI) begin
                    n = i7[2:6];
                end else if (op == OP_ROTQBY) begin
                    n = b[28:31];
                end else begin
                    n = i7[3:6];
                end
                for (int j = 0; j < QUAD_BYTES; j++) begin
                    src = (op == OP_SHLQBYI) ? j + n : (j + n) % QUAD_BYTES;
                    if (src < QUAD_BYTES) begin
                        r[8*j +: 8] = a[8*src +: 8];
                    end
                end
            end
            OP_GBB: begin
                gathered = '0;
                for (int k = 0; k < QUAD_BYTES; k++) begin
                    gathered = {gathered[14:0], a[8*k + 7]};
                end
                r[0:31] = {16'h0000, gathered};
            end
            OP_SHUFB: begin
                for (int j = 0; j < QUAD_BYTES; j++) begin
                    ctl = c[8*j +: 8];
                    if (ctl[7:6] == 2'b10) begin
                        r[8*j +: 8] = 8'h00;
                    end else if (ctl[7:5] == 3'b110) begin
                        r[8*j +: 8] = 8'hFF;
                    end else if (ctl[7:5] == 3'b111) begin
                        r[8*j +: 8] = 8'h80;
                    end else begin
                        src = ctl[4:0];
                        r[8*j +: 8] = (src < 16) ? a[8*src +: 8] : b[8*(src-16) +: 8];
                    end
                end
            end
            default: r = '0;
        endcase
        return r;
    endfunction

    function automatic word_t ls_addr_model(odd_op_t op, quad_t a, quad_t b, imm10_t i10);
        word_t base;
        int    disp;
        base = a[0:31];
        if (op == OP_LQX || op == OP_STQX) begin
            base = base + b[0:31];
        end else begin
            disp = i10;
            if (disp >= 512) begin
                disp = disp - 1024;
            end
            base = base + word_t'(disp * 16);
        end
        return base % LS_BYTES / 16 * 16;
    endfunction

    // applies the instruction taken at the current non-stalled edge
    task automatic model_issue();
        pkt_t  pkt;
        word_t addr;
        int    off;
        logic  take;
        pkt.rt  = rt_addr;
        pkt.due = edge_cnt + 1;
        off = imm16;
        if (off >= 32768) begin
            off = off - 65536;
        end
        off = off * 4;
        if (opcode != OP_LNOP) begin
            exp_taken = 1'b0;
            exp_flush = 1'b0;
        end
        case (opcode)
            OP_SHLQBI, OP_SHLQBYI, OP_ROTQBY, OP_ROTQBYI, OP_GBB, OP_SHUFB: begin
                pkt.value = perm_model(opcode, ra, rb, rc, imm7);
                perm_q.push_back(pkt);
            end
            OP_LQD, OP_LQX: begin
                addr      = ls_addr_model(opcode, ra, rb, imm10);
                pkt.value = ls_mem.exists(addr) ? ls_mem[addr] : '0;
                pkt.due   = edge_cnt + 4;
                ls_q.push_back(pkt);
            end
            OP_STQD, OP_STQX: ls_mem[ls_addr_model(opcode, ra, rb, imm10)] = rc;
            OP_BR, OP_BRA, OP_BRSL: begin
                exp_taken = 1'b1;
                exp_flush = br_first_instr;
                if (opcode == OP_BRA) begin
                    exp_bta = word_t'(off) % LS_BYTES;
                end else begin
                    exp_bta = (pc + word_t'(off)) % LS_BYTES;
                end
                if (opcode == OP_BRSL) begin
                    pkt.value       = '0;
                    pkt.value[0:31] = (pc + 4) % LS_BYTES;
                    br_q.push_back(pkt);
                end
            end
            OP_BRZ, OP_BRNZ: begin
                take      = (rc[0:31] == 0) ^ (opcode == OP_BRNZ);
                exp_taken = take;
                exp_flush = take & br_first_instr;
                exp_bta   = take ? (pc + word_t'(off)) / 4 * 4 : pc + 4;
            end
            default: begin
            end
        endcase
    endtask

    task automatic check_unit(input string name, input logic has, input pkt_t exp,
                              input logic wr_en, input reg_addr_t rt, input quad_t val);
        assert (wr_en === has)
            else stop_on_error($sformatf("FAIL t=%0t %s wr_en expected %b got %b",
                                         $time, name, has, wr_en));
        if (has) begin
            assert (rt === exp.rt)
                else stop_on_error($sformatf("FAIL t=%0t %s rt_addr expected %0d got %0d",
                                             $time, name, exp.rt, rt));
            assert (val === exp.value)
                else stop_on_error($sformatf("FAIL t=%0t %s value expected %h got %h",
                                             $time, name, exp.value, val));
        end
    endtask

    task automatic check_outputs(input logic was_stalled);
        pkt_t perm_exp;
        pkt_t ls_exp;
        pkt_t br_exp;
        logic perm_has;
        logic ls_has;
        logic br_has;
        if (was_stalled) begin
            assert (outputs_now() === snap)
                else stop_on_error($sformatf("FAIL t=%0t outputs changed during stall", $time));
        end else begin
            assert (branch_taken === exp_taken && flush === exp_flush)
                else stop_on_error($sformatf("FAIL t=%0t taken/flush expected %b%b got %b%b",
                                             $time, exp_taken, exp_flush, branch_taken, flush));
            assert (bta === exp_bta)
                else stop_on_error($sformatf("FAIL t=%0t bta expected %h got %h",
                                             $time, exp_bta, bta));
            perm_has = (perm_q.size() > 0) && (perm_q[0].due == edge_cnt);
            ls_has   = (ls_q.size() > 0) && (ls_q[0].due == edge_cnt);
            br_has   = (br_q.size() > 0) && (br_q[0].due == edge_cnt);
            perm_exp = perm_has ? perm_q.pop_front() : '0;
            ls_exp   = ls_has ? ls_q.pop_front() : '0;
            br_exp   = br_has ? br_q.pop_front() : '0;
            check_unit("perm", perm_has, perm_exp, perm_wr_en, perm_rt_addr, perm_value);
            check_unit("ls", ls_has, ls_exp, ls_wr_en, ls_rt_addr, ls_value);
            check_unit("branch", br_has, br_exp, branch_wr_en, branch_rt_addr, branch_value);
        end
        snap = outputs_now();
    endtask

    // one clock, inputs were set 1 ns after the previous edge
    task automatic step();
        logic was_stalled;
        @(posedge clk);
        was_stalled = stall;
        if (!was_stalled) begin
            edge_cnt++;
            model_issue();
        end
        #1;
        check_outputs(was_stalled);
    endtask

    task automatic drive_random();
        int   disp;
        logic is_ls;
        stall          = ($urandom_range(0, 99) < 15);
        opcode         = odd_op_t'($urandom_range(0, 15));
        br_first_instr = $urandom_range(0, 1);
        ra             = {$urandom, $urandom, $urandom, $urandom};
        rb             = {$urandom, $urandom, $urandom, $urandom};
        rc             = {$urandom, $urandom, $urandom, $urandom};
        rt_addr        = $urandom_range(0, 127);
        imm7           = $urandom_range(0, 127);
        imm10          = $urandom_range(0, 1023);
        imm16          = $urandom_range(0, 65535);
        pc             = $urandom;
        is_ls = (opcode == OP_LQD) || (opcode == OP_LQX)
             || (opcode == OP_STQD) || (opcode == OP_STQX);
        // small addresses so loads hit earlier stores
        if (is_ls) begin
            ra[0:31] = $urandom_range(64, 191);
            rb[0:31] = $urandom_range(0, 63);
            disp     = int'($urandom_range(0, 7)) - 4;
            imm10    = disp[9:0];
        end
        if ((opcode == OP_BRZ || opcode == OP_BRNZ) && $urandom_range(0, 1)) begin
            rc[0:31] = '0;
        end
    endtask

    initial begin
        void'($urandom(93));
        reset          = 1'b1;
        stall          = 1'b0;
        br_first_instr = 1'b0;
        opcode         = OP_LNOP;
        ra             = '0;
        rb             = '0;
        rc             = '0;
        rt_addr        = '0;
        imm7           = '0;
        imm10          = '0;
        imm16          = '0;
        pc             = '0;
        edge_cnt       = 0;
        exp_taken      = 1'b0;
        exp_flush      = 1'b0;
        exp_bta        = '0;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        assert (outputs_now() === '0)
            else stop_on_error($sformatf("FAIL t=%0t outputs not cleared by reset", $time));
        snap = outputs_now();

        // zero the reachable lines so every load has a known value
        for (int line = 0; line < LS_LINES; line++) begin
            opcode   = OP_STQD;
            ra       = '0;
            ra[0:31] = line * 16;
            imm10    = '0;
            rc       = '0;
            step();
        end

        issued = 0;
        cycles = 0;
        while (issued < NUM_INSTR && cycles < MAX_CYCLES) begin
            drive_random();
            if (!stall) begin
                issued++;
            end
            cycles++;
            step();
        end
        if (issued < NUM_INSTR) begin
            stop_on_error("timeout: random instruction stream did not complete");
        end

        stall       = 1'b0;
        opcode      = OP_LNOP;
        wait_cycles = 0;
        while ((perm_q.size() + ls_q.size() + br_q.size()) != 0 && wait_cycles < DRAIN_LIMIT) begin
            step();
            wait_cycles++;
        end
        if ((perm_q.size() + ls_q.size() + br_q.size()) == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            stop_on_error("timeout: expected writeback packets still pending after drain");
        end
    end

endmodule

// ==== odd_pipe.f ====
common/spu_odd_pkg.sv
common/odd_issue_if.sv
hdl/result_delay.sv
hdl/branch_unit.sv
permute/permute_unit.sv
load_store/local_store.sv
load_store/ls_unit.sv
hdl/odd_pipe.sv
test/odd_pipe_sva.sv
test/tb_odd_pipe.sv

// ==== Bender.yml ====
package:
  name: odd_pipe

sources:
  - files:
      - common/spu_odd_pkg.sv
      - common/odd_issue_if.sv
      - hdl/result_delay.sv
      - hdl/branch_unit.sv
      - permute/permute_unit.sv
      - load_store/local_store.sv
      - load_store/ls_unit.sv
      - hdl/odd_pipe.sv
  - target: test
    files:
      - test/odd_pipe_sva.sv
      - test/tb_odd_pipe.sv
